/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing -j 0
TOP      = tb_serial_core
FILELIST = project.f
OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

/* hdl/hs_slot.sv */
`timescale 1ns/1ps
`default_nettype none

// One-entry slot for a four-phase req/ack channel
// With IS_RECV clear it is the sender and o_req is the channel req
// With IS_RECV set it is the receiver, o_req is our ack and i_ack the peer req
module hs_slot #(
   parameter type payload_t = logic [31:0],
   parameter bit  IS_RECV   = 1'b0
) (
   input  logic     i_clk,
   input  logic     i_rst_n,
   input  logic     i_load,
   input  payload_t i_data,
   output logic     o_req,
   input  logic     i_ack,
   output payload_t o_data,
   output logic     o_busy
);

   logic     req_q;
   logic     rtz_q;
   logic     take;
   logic     drop;
   payload_t data_q;

   // Receiver also waits for the peer request
   assign take = i_load & ~o_busy & (~IS_RECV | i_ack);

   // Sender drops req on ack, receiver drops ack once req is gone
   assign drop = req_q & (IS_RECV ? ~i_ack : i_ack);

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         req_q <= 1'b0;
         rtz_q <= 1'b0;
      end else if (take) begin
         req_q <= 1'b1;
      end else if (drop) begin
         req_q <= 1'b0;
         // Sender still has to see ack fall
         rtz_q <= ~IS_RECV;
      end else if (rtz_q && !i_ack) begin
         rtz_q <= 1'b0;
      end
   end

   // Payload held from load until the next load
   always_ff @(posedge i_clk) begin
      if (take) begin
         data_q <= i_data;
      end
   end

   assign o_req  = req_q;
   assign o_data = data_q;
   assign o_busy = req_q | rtz_q;

endmodule

`default_nettype wire

/* hdl/isa_pkg.sv */
`default_nettype none

`include "serial_rf_macros.svh"

package isa_pkg;

   // Major opcodes handled by decode
   localparam logic [6:0] OPC_REG    = 7'b0110011;
   localparam logic [6:0] OPC_IMM    = 7'b0010011;
   localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

   // Serial ALU operations
   typedef enum logic [2:0] {
      alu_add,
      alu_sub,
      alu_and,
      alu_or,
      alu_xor
   } alu_op_t;

   // Word handed out on the result channel
   typedef struct packed {
      logic [4:0]           rd;
      logic                 wen;
      logic [`SRF_XLEN-1:0] data;
   } result_t;

endpackage

`default_nettype wire

/* hdl/rf_addr_pkg.sv */
`default_nettype none

package rf_addr_pkg;

   // GPR index, x0 to x31
   typedef logic [4:0] gpr_addr_t;

   // Machine CSR index, offset from the CSR base address
   // Decoded from the 12-bit CSR field of the instruction
   typedef enum logic [1:0] {
      csr_mscratch = 2'd0,
      csr_mtvec    = 2'd1,
      csr_mepc     = 2'd2,
      csr_mtval    = 2'd3
   } csr_idx_t;

endpackage

`default_nettype wire

/* hdl/serial_core_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "serial_rf_macros.svh"

module serial_core_top #(
   parameter int WITH_CSR = 1
) (
   input  logic                   i_clk,
   input  logic                   i_rst_n,
   input  logic                   i_instr_req,
   input  logic [31:0]            i_instr,
   output logic                   o_instr_ack,
   output logic                   o_res_req,
   output rf_addr_pkg::gpr_addr_t o_res_rd,
   output logic                   o_res_wen,
   output logic [`SRF_XLEN-1:0]   o_res_data,
   input  logic                   i_res_ack
);
   import isa_pkg::*;
   import rf_addr_pkg::*;

   localparam int AW = 5 + WITH_CSR;
   localparam int CW = $clog2(`SRF_XLEN);

   // Decoded instruction
   logic        start;
   alu_op_t     op;
   logic        use_imm;
   logic [11:0] imm;
   logic        rd_wen;
   logic        csr_en;
   gpr_addr_t   rd_addr;
   gpr_addr_t   rs1_addr;
   gpr_addr_t   rs2_addr;
   csr_idx_t    csr_idx;

   // Serial datapath
   logic          cnt_en;
   logic [CW-1:0] cnt;
   logic          alu_rd;
   logic          done;
   logic          rs1_bit;
   logic          rs2_bit;
   logic          csr_bit;

   // RAM ports
   logic [AW-1:0] wreg0;
   logic [AW-1:0] wreg1;
   logic [AW-1:0] rreg0;
   logic [AW-1:0] rreg1;
   logic          wen0;
   logic          wen1;
   logic          wdata0;
   logic          wdata1;
   logic          rdata0;
   logic          rdata1;

   logic    res_busy;
   result_t res;

   serial_decode #(.WITH_CSR(WITH_CSR)) u_decode (
      .i_clk      (i_clk),
      .i_rst_n    (i_rst_n),
      .i_instr_req(i_instr_req),
      .i_instr    (i_instr),
      .o_instr_ack(o_instr_ack),
      // One instruction in flight
      .i_idle     (~cnt_en & ~res_busy),
      .o_start    (start),
      .o_op       (op),
      .o_use_imm  (use_imm),
      .o_imm      (imm),
      .o_rd_wen   (rd_wen),
      .o_csr_en   (csr_en),
      .o_rd_addr  (rd_addr),
      .o_rs1_addr (rs1_addr),
      .o_rs2_addr (rs2_addr),
      .o_csr_idx  (csr_idx)
   );

   serial_exec u_exec (
      .i_clk    (i_clk),
      .i_rst_n  (i_rst_n),
      .i_start  (start),
      .i_op     (op),
      .i_use_imm(use_imm),
      .i_imm    (imm),
      .i_rs1    (rs1_bit),
      .i_rs2    (rs2_bit),
      .o_cnt_en (cnt_en),
      .o_cnt    (cnt),
      .o_alu_rd (alu_rd),
      .o_done   (done)
   );

   // CSRRW takes rd from the old CSR and writes rs1 into it
   serial_rf_if #(.WITH_CSR(WITH_CSR)) u_rf_if (
      .i_cnt_en   (cnt_en),
      .i_rd_wen   (rd_wen),
      .i_rd_waddr (rd_addr),
      .i_alu_rd   (alu_rd),
      .i_rd_alu_en(~csr_en),
      .i_csr_rd   (csr_bit),
      .i_rd_csr_en(csr_en),
      .i_csr_en   (csr_en),
      .i_csr_addr (csr_idx),
      .i_csr      (rs1_bit),
      .i_rs1_raddr(rs1_addr),
      .i_rs2_raddr(rs2_addr),
      .i_rdata0   (rdata0),
      .i_rdata1   (rdata1),
      .o_wreg0    (wreg0),
      .o_wreg1    (wreg1),
      .o_wen0     (wen0),
      .o_wen1     (wen1),
      .o_wdata0   (wdata0),
      .o_wdata1   (wdata1),
      .o_rreg0    (rreg0),
      .o_rreg1    (rreg1),
      .o_rs1      (rs1_bit),
      .o_rs2      (rs2_bit),
      .o_csr      (csr_bit)
   );

   serial_rf_ram #(.WITH_CSR(WITH_CSR)) u_rf_ram (
      .i_clk   (i_clk),
      .i_rst_n (i_rst_n),
      .i_cnt   (cnt),
      .i_wreg0 (wreg0),
      .i_wreg1 (wreg1),
      .i_wen0  (wen0),
      .i_wen1  (wen1),
      .i_wdata0(wdata0),
      .i_wdata1(wdata1),
      .i_rreg0 (rreg0),
      .i_rreg1 (rreg1),
      .o_rdata0(rdata0),
      .o_rdata1(rdata1)
   );

   // Collects the selected rd bit stream
   serial_result u_result (
      .i_clk    (i_clk),
      .i_rst_n  (i_rst_n),
      .i_cnt_en (cnt_en),
      .i_cnt    (cnt),
      .i_rd_bit (wdata0),
      .i_done   (done),
      .i_rd_addr(rd_addr),
      .i_rd_wen (rd_wen),
      .o_res_req(o_res_req),
      .i_res_ack(i_res_ack),
      .o_res    (res),
      .o_busy   (res_busy)
   );

   assign o_res_rd   = res.rd;
   assign o_res_wen  = res.wen;
   assign o_res_data = res.data;

endmodule

`default_nettype wire

/* hdl/serial_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module serial_decode #(
   parameter int WITH_CSR = 1
) (
   input  logic                   i_clk,
   input  logic                   i_rst_n,
   input  logic                   i_instr_req,
   input  logic [31:0]            i_instr,
   output logic                   o_instr_ack,
   input  logic                   i_idle,
   output logic                   o_start,
   output isa_pkg::alu_op_t       o_op,
   output logic                   o_use_imm,
   output logic [11:0]            o_imm,
   output logic                   o_rd_wen,
   output logic                   o_csr_en,
   output rf_addr_pkg::gpr_addr_t o_rd_addr,
   output rf_addr_pkg::gpr_addr_t o_rs1_addr,
   output rf_addr_pkg::gpr_addr_t o_rs2_addr,
   output rf_addr_pkg::csr_idx_t  o_csr_idx
);
   import isa_pkg::*;
   import rf_addr_pkg::*;

   logic [31:0] instr;
   logic        busy;
   logic        busy_d;
   logic        start_q;
   logic [2:0]  funct3;
   logic        csr_ok;

   // Receiver slot, no new word while a pass is pending
   hs_slot #(
      .payload_t(logic [31:0]),
      .IS_RECV  (1'b1)
   ) u_instr_slot (
      .i_clk  (i_clk),
      .i_rst_n(i_rst_n),
      .i_load (i_idle & ~start_q),
      .i_data (i_instr),
      .o_req  (o_instr_ack),
      .i_ack  (i_instr_req),
      .o_data (instr),
      .o_busy (busy)
   );

   // Start one cycle after ack rises
   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         busy_d  <= 1'b0;
         start_q <= 1'b0;
      end else begin
         busy_d  <= busy;
         start_q <= busy & ~busy_d;
      end
   end

   assign o_start    = start_q;
   assign funct3     = instr[14:12];
   assign o_imm      = instr[31:20];
   assign o_rd_addr  = instr[11:7];
   assign o_rs1_addr = instr[19:15];
   assign o_rs2_addr = instr[24:20];

   // CSR number to RAM slot
   always_comb begin
      csr_ok    = 1'b1;
      o_csr_idx = csr_mscratch;
      case (instr[31:20])
         12'h340: o_csr_idx = csr_mscratch;
         12'h305: o_csr_idx = csr_mtvec;
         12'h341: o_csr_idx = csr_mepc;
         12'h343: o_csr_idx = csr_mtval;
         default: csr_ok = 1'b0;
      endcase
   end

   // Unsupported encodings run a pass with no writes
   always_comb begin
      o_op      = alu_add;
      o_use_imm = 1'b0;
      o_rd_wen  = 1'b0;
      o_csr_en  = 1'b0;
      case (instr[6:0])
         OPC_REG: begin
            o_rd_wen = (instr[31:25] == 7'h00) || (instr[31:25] == 7'h20 && funct3 == 3'b000);
            case (funct3)
               3'b000:  o_op = instr[30] ? alu_sub : alu_add;
               3'b100:  o_op = alu_xor;
               3'b110:  o_op = alu_or;
               3'b111:  o_op = alu_and;
               default: o_rd_wen = 1'b0;
            endcase
         end
         OPC_IMM: begin
            // ADDI only
            o_use_imm = 1'b1;
            o_rd_wen  = (funct3 == 3'b000);
         end
         OPC_SYSTEM: begin
            // CSRRW, old value to rd
            if (WITH_CSR != 0 && funct3 == 3'b001 && csr_ok) begin
               o_csr_en = 1'b1;
               o_rd_wen = 1'b1;
            end
         end
         default: ;
      endcase
   end

endmodule

`default_nettype wire

/* hdl/serial_exec.sv */
`timescale 1ns/1ps
`default_nettype none

`include "serial_rf_macros.svh"

module serial_exec (
   input  logic                         i_clk,
   input  logic                         i_rst_n,
   input  logic                         i_start,
   input  isa_pkg::alu_op_t             i_op,
   input  logic                         i_use_imm,
   input  logic [11:0]                  i_imm,
   input  logic                         i_rs1,
   input  logic                         i_rs2,
   output logic                         o_cnt_en,
   output logic [$clog2(`SRF_XLEN)-1:0] o_cnt,
   output logic                         o_alu_rd,
   output logic                         o_done
);
   import isa_pkg::*;

   localparam int CW = $clog2(`SRF_XLEN);

   logic          cnt_en_q;
   logic [CW-1:0] cnt_q;
   logic          carry_q;
   logic [11:0]   imm_q;
   logic          is_sub;
   logic          op_b;
   logic          b_eff;
   logic          sum;

   // Second operand, immediate replaces rs2 for ADDI
   assign is_sub = (i_op == alu_sub);
   assign op_b   = i_use_imm ? imm_q[0] : i_rs2;
   // Subtract as rs1 + ~rs2 + 1
   assign b_eff  = op_b ^ is_sub;
   assign sum    = i_rs1 ^ b_eff ^ carry_q;
   assign o_done = cnt_en_q & (cnt_q == CW'(`SRF_XLEN - 1));

   // Bit counter and carry
   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         cnt_en_q <= 1'b0;
         cnt_q    <= '0;
         carry_q  <= 1'b0;
      end else if (i_start) begin
         cnt_en_q <= 1'b1;
         cnt_q    <= '0;
         carry_q  <= is_sub;
      end else if (cnt_en_q) begin
         cnt_q   <= cnt_q + 1'b1;
         carry_q <= (i_rs1 & b_eff) | (carry_q & (i_rs1 ^ b_eff));
         // Last bit ends the pass
         if (o_done) begin
            cnt_en_q <= 1'b0;
         end
      end
   end

   // Immediate shifts out LSB first with sign fill
   always_ff @(posedge i_clk) begin
      if (i_start) begin
         imm_q <= i_imm;
      end else if (cnt_en_q) begin
         imm_q <= {imm_q[11], imm_q[11:1]};
      end
   end

   // One result bit per cycle
   always_comb begin
      case (i_op)
         alu_and: o_alu_rd = i_rs1 & op_b;
         alu_or:  o_alu_rd = i_rs1 | op_b;
         alu_xor: o_alu_rd = i_rs1 ^ op_b;
         default: o_alu_rd = sum;
      endcase
   end

   assign o_cnt_en = cnt_en_q;
   assign o_cnt    = cnt_q;

endmodule

`default_nettype wire

/* hdl/serial_result.sv */
`timescale 1ns/1ps
`default_nettype none

`include "serial_rf_macros.svh"

module serial_result (
   input  logic                         i_clk,
   input  logic                         i_rst_n,
   input  logic                         i_cnt_en,
   input  logic [$clog2(`SRF_XLEN)-1:0] i_cnt,
   input  logic                         i_rd_bit,
   input  logic                         i_done,
   input  rf_addr_pkg::gpr_addr_t       i_rd_addr,
   input  logic                         i_rd_wen,
   output logic                         o_res_req,
   input  logic                         i_res_ack,
   output isa_pkg::result_t             o_res,
   output logic                         o_busy
);
   import isa_pkg::*;

   logic [`SRF_XLEN-1:0] word_q;
   logic [`SRF_XLEN-1:0] word_next;
   result_t              res_in;

   // Current bit lands at its own position
   always_comb begin
      word_next = word_q;
      if (i_cnt_en) begin
         word_next[i_cnt] = i_rd_bit;
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_cnt_en) begin
         word_q <= word_next;
      end
   end

   // Last bit goes straight into the slot with done
   assign res_in = '{rd: i_rd_addr, wen: i_rd_wen & (|i_rd_addr), data: word_next};

   hs_slot #(
      .payload_t(result_t),
      .IS_RECV  (1'b0)
   ) u_res_slot (
      .i_clk  (i_clk),
      .i_rst_n(i_rst_n),
      .i_load (i_done),
      .i_data (res_in),
      .o_req  (o_res_req),
      .i_ack  (i_res_ack),
      .o_data (o_res),
      .o_busy (o_busy)
   );

endmodule

`default_nettype wire

/* hdl/serial_rf_if.sv */
`timescale 1ns/1ps
`default_nettype none

`include "serial_rf_macros.svh"

module serial_rf_if #(
   parameter int WITH_CSR = 1
) (
   input  logic                   i_cnt_en,
   input  logic                   i_rd_wen,
   input  rf_addr_pkg::gpr_addr_t i_rd_waddr,
   input  logic                   i_alu_rd,
   input  logic                   i_rd_alu_en,
   input  logic                   i_csr_rd,
   input  logic                   i_rd_csr_en,
   input  logic                   i_csr_en,
   input  rf_addr_pkg::csr_idx_t  i_csr_addr,
   input  logic                   i_csr,
   input  rf_addr_pkg::gpr_addr_t i_rs1_raddr,
   input  rf_addr_pkg::gpr_addr_t i_rs2_raddr,
   input  logic                   i_rdata0,
   input  logic                   i_rdata1,
   output logic [4+WITH_CSR:0]    o_wreg0,
   output logic [4+WITH_CSR:0]    o_wreg1,
   output logic                   o_wen0,
   output logic                   o_wen1,
   output logic                   o_wdata0,
   output logic                   o_wdata1,
   output logic [4+WITH_CSR:0]    o_rreg0,
   output logic [4+WITH_CSR:0]    o_rreg1,
   output logic                   o_rs1,
   output logic                   o_rs2,
   output logic                   o_csr
);

   localparam int AW = 5 + WITH_CSR;

   logic          csr_on;
   logic [AW-1:0] csr_reg;
   logic          rd_bit;

   // No CSR traffic in the 32-entry variant
   assign csr_on  = (WITH_CSR != 0) && i_csr_en;
   // CSRs sit right after the GPRs
   assign csr_reg = AW'(`SRF_CSR_BASE + int'(i_csr_addr));

   // rd from the ALU, or the old CSR value for CSRRW
   assign rd_bit = (i_alu_rd & i_rd_alu_en) | (i_csr_rd & i_rd_csr_en);

   // Port 0 writes rd, x0 never written
   assign o_wreg0  = AW'(i_rd_waddr);
   assign o_wen0   = i_cnt_en & i_rd_wen & (|i_rd_waddr);
   assign o_wdata0 = rd_bit;

   // Port 1 writes the CSR, new value is the rs1 bit
   assign o_wreg1  = csr_reg;
   assign o_wen1   = i_cnt_en & csr_on;
   assign o_wdata1 = i_csr;

   // Port 0 reads rs1, port 1 reads rs2 or the CSR
   assign o_rreg0 = AW'(i_rs1_raddr);
   assign o_rreg1 = csr_on ? csr_reg : AW'(i_rs2_raddr);

   assign o_rs1 = i_rdata0;
   assign o_rs2 = i_rdata1;
   assign o_csr = i_rdata1 & csr_on;

endmodule

`default_nettype wire

/* hdl/serial_rf_ram.sv */
`timescale 1ns/1ps
`default_nettype none

`include "serial_rf_macros.svh"

module serial_rf_ram #(
   parameter int WITH_CSR = 1
) (
   input  logic                         i_clk,
   input  logic                         i_rst_n,
   input  logic [$clog2(`SRF_XLEN)-1:0] i_cnt,
   input  logic [4+WITH_CSR:0]          i_wreg0,
   input  logic [4+WITH_CSR:0]          i_wreg1,
   input  logic                         i_wen0,
   input  logic                         i_wen1,
   input  logic                         i_wdata0,
   input  logic                         i_wdata1,
   input  logic [4+WITH_CSR:0]          i_rreg0,
   input  logic [4+WITH_CSR:0]          i_rreg1,
   output logic                         o_rdata0,
   output logic                         o_rdata1
);

   // GPRs plus four CSRs when enabled
   localparam int DEPTH = `SRF_NUM_GPR + (WITH_CSR != 0 ? 4 : 0);

   logic [`SRF_XLEN-1:0] mem [DEPTH];

   // One bit per port per clock, at the current bit count
   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         for (int i = 0; i < DEPTH; i++) begin
            mem[i] <= '0;
         end
      end else begin
         if (i_wen0) begin
            mem[i_wreg0][i_cnt] <= i_wdata0;
         end
         if (i_wen1) begin
            mem[i_wreg1][i_cnt] <= i_wdata1;
         end
      end
   end

   // Combinational reads, x0 hardwired to zero
   assign o_rdata0 = (i_rreg0 == '0) ? 1'b0 : mem[i_rreg0][i_cnt];
   assign o_rdata1 = (i_rreg1 == '0) ? 1'b0 : mem[i_rreg1][i_cnt];

endmodule

`default_nettype wire

/* include/serial_rf_macros.svh */
`ifndef SERIAL_RF_MACROS_SVH
`define SERIAL_RF_MACROS_SVH

// Data word width, one bit per cycle
`define SRF_XLEN 32

// General purpose registers x0 to x31
`define SRF_NUM_GPR 32

// First CSR address in the register RAM
// mscratch, mtvec, mepc and mtval follow in that order
`define SRF_CSR_BASE 32

`endif

/* project.f */
+incdir+include
hdl/rf_addr_pkg.sv
hdl/isa_pkg.sv
hdl/hs_slot.sv
hdl/serial_decode.sv
hdl/serial_exec.sv
hdl/serial_rf_if.sv
hdl/serial_rf_ram.sv
hdl/serial_result.sv
hdl/serial_core_top.sv
tb/tb_clk_gen.sv
tb/tb_serial_core.sv

/* tb/tb_clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
   parameter int PERIOD_NS    = 100,
   parameter int RESET_CYCLES = 16
) (
   output logic o_clk,
   output logic o_rst_n
);

   // Free-running clock
   initial begin
      o_clk = 1'b0;
      forever #(PERIOD_NS / 2) o_clk = ~o_clk;
   end

   // Reset released on a rising edge
   initial begin
      o_rst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge o_clk);
      o_rst_n <= 1'b1;
   end

endmodule

`default_nettype wire

/* tb/tb_serial_core.sv */
`timescale 1ns/1ps
`default_nettype none

`include "serial_rf_macros.svh"

module tb_serial_core;

   localparam int NUM_INSTR = 95;
   localparam int CYCLE_NS  = 100;
   localparam int HS_LIMIT  = 200;
   // Reset plus 80 cycles per instruction
   localparam longint WATCHDOG_NS = longint'(16 + NUM_INSTR * 80) * CYCLE_NS;

   // RV32 major opcodes
   localparam logic [6:0] OP_REG = 7'b0110011;
   localparam logic [6:0] OP_IMM = 7'b0010011;
   localparam logic [6:0] OP_SYS = 7'b1110011;
   // mscratch, mtvec, mepc, mtval
   localparam logic [11:0] CSR_NUM [4] = '{12'h340, 12'h305, 12'h341, 12'h343};

   logic                 clk;
   logic                 rst_n;
   logic                 instr_req;
   logic [31:0]          instr;
   logic                 instr_ack;
   logic                 res_req;
   logic [4:0]           res_rd;
   logic                 res_wen;
   logic [`SRF_XLEN-1:0] res_data;
   logic                 res_ack;

   // Reference model of the register file
   logic [31:0] gpr [32];
   logic [31:0] csr [4];
   integer      seed;

   tb_clk_gen #(.PERIOD_NS(CYCLE_NS), .RESET_CYCLES(16)) u_clk_gen (
      .o_clk  (clk),
      .o_rst_n(rst_n)
   );

   serial_core_top #(.WITH_CSR(1)) uut (
      .i_clk      (clk),
      .i_rst_n    (rst_n),
      .i_instr_req(instr_req),
      .i_instr    (instr),
      .o_instr_ack(instr_ack),
      .o_res_req  (res_req),
      .o_res_rd   (res_rd),
      .o_res_wen  (res_wen),
      .o_res_data (res_data),
      .i_res_ack  (res_ack)
   );

   task automatic stop_run(input string why);
      $display("%s", why);
      $display("Result: FAILED");
      $fatal(1, "simulation stopped");
   endtask

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         stop_run($sformatf("FAILED at %0t ns: %s is %h, expected %h", $time, name, got, exp));
      end
   endtask

   // One clock, bounded wait for a handshake edge
   task automatic tick(inout int n, input string what);
      @(posedge clk);
      n++;
      if (n > HS_LIMIT) begin
         stop_run({"No response from the DUT while waiting for ", what});
      end
   endtask

   // Rest of the instruction handshake, req already up
   task automatic finish_instr();
      int n;
      n = 0;
      while (!instr_ack) begin
         tick(n, "the instruction ack");
      end
      instr_req <= 1'b0;
      n = 0;
      while (instr_ack) begin
         tick(n, "the instruction ack to drop");
      end
   endtask

   task automatic send_instr(input logic [31:0] word);
      instr     <= word;
      instr_req <= 1'b1;
      finish_instr();
   endtask

   // Result handshake, ack held back for hold cycles
   task automatic take_result(input logic [4:0] rd, input logic wen, input logic [31:0] data,
                              input logic chk_data, input int hold);
      int          n;
      logic [31:0] held;
      n = 0;
      while (!res_req) begin
         tick(n, "the result req");
      end
      held = res_data;
      repeat (hold) begin
         @(posedge clk);
         check("o_res_req", 32'(res_req), 32'd1);
         check("o_res_data", res_data, held);
         // No new instruction while the result waits
         check("o_instr_ack", 32'(instr_ack), 32'd0);
      end
      check("o_res_rd", 32'(res_rd), 32'(rd));
      check("o_res_wen", 32'(res_wen), 32'(wen));
      if (chk_data) begin
         check("o_res_data", res_data, data);
      end
      res_ack <= 1'b1;
      n = 0;
      while (res_req) begin
         tick(n, "the result req to drop");
      end
      res_ack <= 1'b0;
   endtask

   function automatic logic [31:0] alu_ref(input int op, input logic [31:0] a,
                                           input logic [31:0] b);
      case (op)
         0:       return a + b;
         1:       return a - b;
         2:       return a & b;
         3:       return a | b;
         default: return a ^ b;
      endcase
   endfunction

   // R-type word, op 0 to 4 is add sub and or xor
   function automatic logic [31:0] encode_r(input int op, input logic [4:0] rd,
                                            input logic [4:0] rs1, input logic [4:0] rs2);
      logic [2:0] f3;
      logic [6:0] f7;
      f7 = (op == 1) ? 7'h20 : 7'h00;
      case (op)
         2:       f3 = 3'b111;
         3:       f3 = 3'b110;
         4:       f3 = 3'b100;
         default: f3 = 3'b000;
      endcase
      return {f7, rs2, rs1, f3, rd, OP_REG};
   endfunction

   function automatic logic [4:0] pick_rd();
      return 5'(1 + $unsigned($random(seed)) % 31);
   endfunction

   task automatic run_alu(input int op, input logic [4:0] rd, input logic [4:0] rs1,
                          input logic [4:0] rs2);
      logic [31:0] exp;
      exp = alu_ref(op, gpr[rs1], gpr[rs2]);
      send_instr(encode_r(op, rd, rs1, rs2));
      // x0 result data is not checked, only the missing write
      take_result(rd, rd != 0, exp, rd != 0, 0);
      if (rd != 0) begin
         gpr[rd] = exp;
      end
   endtask

   task automatic run_addi(input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
      logic [31:0] exp;
      exp = gpr[rs1] + {{20{imm[11]}}, imm};
      send_instr({imm, rs1, 3'b000, rd, OP_IMM});
      take_result(rd, rd != 0, exp, rd != 0, 0);
      if (rd != 0) begin
         gpr[rd] = exp;
      end
   endtask

   // Old CSR to rd, rs1 into the CSR
   task automatic run_csrrw(input int k, input logic [4:0] rd, input logic [4:0] rs1);
      logic [31:0] old;
      old = csr[k];
      send_instr({CSR_NUM[k], rs1, 3'b001, rd, OP_SYS});
      take_result(rd, rd != 0, old, 1'b1, 0);
      csr[k] = gpr[rs1];
      if (rd != 0) begin
         gpr[rd] = old;
      end
   endtask

   task automatic test_addi();
      for (int r = 1; r < 32; r++) begin
         run_addi(5'(r), 5'd0, 12'($random(seed)));
      end
   endtask

   task automatic test_alu_ops();
      for (int op = 0; op < 5; op++) begin
         repeat (8) begin
            run_alu(op, pick_rd(), 5'($random(seed)), 5'($random(seed)));
         end
      end
   endtask

   task automatic test_x0_write();
      run_alu(0, 5'd0, 5'd1, 5'd2);
      run_addi(5'd0, 5'd0, 12'h7ff);
      // x0 still reads as zero
      run_alu(0, 5'd5, 5'd0, 5'd3);
      run_alu(3, 5'd6, 5'd0, 5'd0);
   endtask

   task automatic test_csrrw();
      for (int k = 0; k < 4; k++) begin
         run_csrrw(k, 5'(20 + k), 5'(1 + k));
         run_csrrw(k, 5'(24 + k), 5'(5 + k));
         // Source register unchanged by the CSR write
         run_alu(0, 5'd28, 5'(1 + k), 5'd0);
      end
   endtask

   task automatic test_backpressure();
      int          op;
      int          hold;
      int          n;
      logic [4:0]  rd;
      logic [4:0]  rd2;
      logic [4:0]  rs1;
      logic [4:0]  rs2;
      logic [31:0] exp;
      repeat (4) begin
         op   = int'($unsigned($random(seed)) % 5);
         hold = int'(2 + $unsigned($random(seed)) % 12);
         rd   = pick_rd();
         rd2  = pick_rd();
         rs1  = 5'($random(seed));
         rs2  = 5'($random(seed));
         exp  = alu_ref(op, gpr[rs1], gpr[rs2]);
         send_instr(encode_r(op, rd, rs1, rs2));
         n = 0;
         while (!res_req) begin
            tick(n, "the result req");
         end
         // Next word waits behind the held result, copies rd into rd2
         instr     <= encode_r(0, rd2, rd, 5'd0);
         instr_req <= 1'b1;
         take_result(rd, 1'b1, exp, 1'b1, hold);
         gpr[rd] = exp;
         finish_instr();
         take_result(rd2, 1'b1, exp, 1'b1, 0);
         gpr[rd2] = exp;
      end
   endtask

   initial begin
      seed      = 32'he158_28d7;
      instr_req = 1'b0;
      instr     = '0;
      res_ack   = 1'b0;
      for (int i = 0; i < 32; i++) begin
         gpr[i] = '0;
      end
      for (int i = 0; i < 4; i++) begin
         csr[i] = '0;
      end
      @(posedge rst_n);
      @(posedge clk);
      check("o_instr_ack", 32'(instr_ack), 32'd0);
      check("o_res_req", 32'(res_req), 32'd0);
      test_addi();
      test_alu_ops();
      test_x0_write();
      test_csrrw();
      test_backpressure();
      $display("Result: PASSED");
      $finish;
   end

   // Watchdog
   initial begin
      #(WATCHDOG_NS);
      stop_run("Watchdog expired before all tests finished");
   end

endmodule

`default_nettype wire
